//--- source/fm_pkg.sv
////////////////////////////////////////////////////////////////////////////
// FM register block shared definitions
// field widths, host register numbers, divider limits and the
// channel update kinds passed from the decoder to the store
////////////////////////////////////////////////////////////////////////////

package fm_pkg;

	// meaningful widths
	typedef logic [7:0]  reg_addr_t;
	typedef logic [2:0]  chan_t;
	typedef logic [10:0] fnum_t;
	typedef logic [2:0]  block_t;
	typedef logic [2:0]  alg_t;
	typedef logic [2:0]  fb_t;
	typedef logic [9:0]  tmr_a_t;
	typedef logic [7:0]  tmr_b_t;
	typedef logic [2:0]  div_t;

	// global registers
	localparam reg_addr_t REG_CLKA1 = 8'h24;
	localparam reg_addr_t REG_CLKA2 = 8'h25;
	localparam reg_addr_t REG_CLKB  = 8'h26;
	localparam reg_addr_t REG_TIMER = 8'h27;
	localparam reg_addr_t REG_DIV6  = 8'h2D;
	localparam reg_addr_t REG_DIV3  = 8'h2E;
	localparam reg_addr_t REG_DIV2  = 8'h2F;

	// channel register bases, low two bits pick the channel
	localparam reg_addr_t REG_FNUM_LO = 8'hA0;
	localparam reg_addr_t REG_FNUM_HI = 8'hA4;
	localparam reg_addr_t REG_FB_ALG  = 8'hB0;

	// divider limit is ratio minus one
	localparam div_t DIV_LIM6 = 3'd5;
	localparam div_t DIV_LIM3 = 3'd2;
	localparam div_t DIV_LIM2 = 3'd1;

	localparam int NUM_SLOTS = 6;

	// channel update kinds
	localparam logic [1:0] UPD_LO    = 2'd0;
	localparam logic [1:0] UPD_HI    = 2'd1;
	localparam logic [1:0] UPD_FBALG = 2'd2;

endpackage

//--- source/fm_timebase.sv
////////////////////////////////////////////////////////////////////////////
// FM timebase
// divides cen by 6, 3 or 2 into clk_en and steps the channel slot
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fm_timebase (
	input  logic          clk,
	input  logic          rst,
	input  logic          cen,
	input  fm_pkg::div_t  div_lim,
	output logic          clk_en,
	output fm_pkg::chan_t slot
);

	fm_pkg::div_t cnt;
	fm_pkg::div_t lim_q;
	logic         wrap;

	assign wrap   = (cnt == lim_q);
	assign clk_en = cen & wrap;

	// new ratio is only picked up when the count wraps
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt   <= '0;
			lim_q <= fm_pkg::DIV_LIM6;
		end else if (cen) begin
			if (wrap) begin
				cnt   <= '0;
				lim_q <= div_lim;
			end else begin
				cnt <= cnt + 3'd1;
			end
		end
	end

	// slot counter, modulo six
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
		end else if (clk_en) begin
			if (slot == fm_pkg::chan_t'(fm_pkg::NUM_SLOTS - 1))
				slot <= '0;
			else
				slot <= slot + 3'd1;
		end
	end

endmodule

//--- source/fm_mmr.sv
////////////////////////////////////////////////////////////////////////////
// FM host register decoder
// two-address write port, global fields for timers and divider,
// and the busy FSM that waits for clk_en or the channel update
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fm_mmr (
	input  logic           clk,
	input  logic           rst,
	input  logic [7:0]     din,
	input  logic [1:0]     addr,
	input  logic           write,
	input  logic           clk_en,
	output logic           busy,
	output fm_pkg::div_t   div_lim,
	output fm_pkg::tmr_a_t val_a,
	output fm_pkg::tmr_b_t val_b,
	output logic           load_a,
	output logic           load_b,
	output logic           irq_en_a,
	output logic           irq_en_b,
	output logic           clr_a,
	output logic           clr_b,
	output logic           upd_req,
	output fm_pkg::chan_t  upd_ch,
	output logic [1:0]     upd_kind,
	output logic [7:0]     upd_data,
	input  logic           upd_done
);

	typedef enum logic [1:0] {
		IDLE,
		GLOBAL_WAIT,
		CHAN_WAIT
	} state_t;

	state_t            state;
	logic              write_q;
	logic              wr_edge;
	logic              data_wr;
	fm_pkg::reg_addr_t reg_sel;
	logic              sel_hi;
	logic              is_global;
	logic              is_chan;
	logic [1:0]        kind;
	fm_pkg::chan_t     chan;

	assign wr_edge   = write & ~write_q;
	// data writes while busy are dropped
	assign data_wr   = wr_edge & addr[0] & (state == IDLE);
	assign is_global = (reg_sel < 8'h30);
	assign busy      = (state != IDLE);
	assign upd_req   = (state == CHAN_WAIT);

	// channel register decode, numbers ending in 3 fall through
	always_comb begin
		is_chan = 1'b0;
		kind    = fm_pkg::UPD_LO;
		if (reg_sel[1:0] != 2'b11) begin
			case ({reg_sel[7:2], 2'b00})
				fm_pkg::REG_FNUM_LO: begin
					is_chan = 1'b1;
					kind    = fm_pkg::UPD_LO;
				end
				fm_pkg::REG_FNUM_HI: begin
					is_chan = 1'b1;
					kind    = fm_pkg::UPD_HI;
				end
				fm_pkg::REG_FB_ALG: begin
					is_chan = 1'b1;
					kind    = fm_pkg::UPD_FBALG;
				end
				default: is_chan = 1'b0;
			endcase
		end
	end

	// upper half adds three to the channel
	assign chan = sel_hi ? ({1'b0, reg_sel[1:0]} + 3'd3) : {1'b0, reg_sel[1:0]};

	always_ff @(posedge clk) begin
		if (rst) begin
			write_q <= 1'b0;
			reg_sel <= '0;
			sel_hi  <= 1'b0;
		end else begin
			write_q <= write;
			if (wr_edge && !addr[0]) begin
				reg_sel <= din;
				sel_hi  <= addr[1];
			end
		end
	end

	// global fields, clear bits are one clk pulses
	always_ff @(posedge clk) begin
		if (rst) begin
			div_lim  <= fm_pkg::DIV_LIM6;
			val_a    <= '0;
			val_b    <= '0;
			load_a   <= 1'b0;
			load_b   <= 1'b0;
			irq_en_a <= 1'b0;
			irq_en_b <= 1'b0;
			clr_a    <= 1'b0;
			clr_b    <= 1'b0;
		end else begin
			clr_a <= 1'b0;
			clr_b <= 1'b0;
			if (data_wr && is_global) begin
				case (reg_sel)
					fm_pkg::REG_CLKA1: val_a[9:2] <= din;
					fm_pkg::REG_CLKA2: val_a[1:0] <= din[1:0];
					fm_pkg::REG_CLKB:  val_b <= din;
					fm_pkg::REG_TIMER: begin
						{clr_b, clr_a, irq_en_b, irq_en_a, load_b, load_a} <= din[5:0];
					end
					fm_pkg::REG_DIV6: div_lim <= fm_pkg::DIV_LIM6;
					fm_pkg::REG_DIV3: div_lim <= fm_pkg::DIV_LIM3;
					fm_pkg::REG_DIV2: div_lim <= fm_pkg::DIV_LIM2;
					default: ;
				endcase
			end
		end
	end

	// request payload, held for the store while upd_req is up
	always_ff @(posedge clk) begin
		if (data_wr && is_chan) begin
			upd_ch   <= chan;
			upd_kind <= kind;
			upd_data <= din;
		end
	end

	// anything that is not a channel update ends on the next clk_en
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (data_wr)
						state <= is_chan ? CHAN_WAIT : GLOBAL_WAIT;
				end
				GLOBAL_WAIT: if (clk_en) state <= IDLE;
				CHAN_WAIT:   if (upd_done) state <= IDLE;
				default:     state <= IDLE;
			endcase
		end
	end

endmodule

//--- source/fm_timers.sv
////////////////////////////////////////////////////////////////////////////
// FM timers
// timer A (10 bit) and timer B (8 bit, prescaled) reloading up-counters
// with sticky overflow flags and a registered interrupt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fm_timers #(
	parameter int TMR_B_PRE = 16
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           clk_en,
	input  fm_pkg::tmr_a_t val_a,
	input  fm_pkg::tmr_b_t val_b,
	input  logic           load_a,
	input  logic           load_b,
	input  logic           irq_en_a,
	input  logic           irq_en_b,
	input  logic           clr_a,
	input  logic           clr_b,
	output logic           flag_a,
	output logic           flag_b,
	output logic           irq
);

	localparam int PRE_W = (TMR_B_PRE > 1) ? $clog2(TMR_B_PRE) : 1;
	localparam logic [PRE_W-1:0] PRE_LIM = PRE_W'(TMR_B_PRE - 1);

	fm_pkg::tmr_a_t   cnt_a;
	fm_pkg::tmr_b_t   cnt_b;
	logic [PRE_W-1:0] pre_cnt;
	logic             step_b;
	logic             ovf_a;
	logic             ovf_b;

	assign step_b = clk_en & (pre_cnt == PRE_LIM);
	assign ovf_a  = clk_en & load_a & (cnt_a == '1);
	assign ovf_b  = step_b & load_b & (cnt_b == '1);

	// counter sits at the load value until enabled
	always_ff @(posedge clk) begin
		if (!load_a)
			cnt_a <= val_a;
		else if (clk_en)
			cnt_a <= (cnt_a == '1) ? val_a : cnt_a + 10'd1;
	end

	// prescaler restarts with the timer so the first step is a full period
	always_ff @(posedge clk) begin
		if (rst || !load_b)
			pre_cnt <= '0;
		else if (clk_en)
			pre_cnt <= (pre_cnt == PRE_LIM) ? '0 : pre_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!load_b)
			cnt_b <= val_b;
		else if (step_b)
			cnt_b <= (cnt_b == '1) ? val_b : cnt_b + 8'd1;
	end

	// clear wins over a set in the same clk
	always_ff @(posedge clk) begin
		if (rst) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
			irq    <= 1'b0;
		end else begin
			if (clr_a)
				flag_a <= 1'b0;
			else if (ovf_a && irq_en_a)
				flag_a <= 1'b1;
			if (clr_b)
				flag_b <= 1'b0;
			else if (ovf_b && irq_en_b)
				flag_b <= 1'b1;
			irq <= flag_a | flag_b;
		end
	end

endmodule

//--- source/fm_chan_regs.sv
////////////////////////////////////////////////////////////////////////////
// FM channel parameter store
// six entries of fnum, block, feedback and algorithm, written in the
// channel's own slot and streamed out one slot per clk_en
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fm_chan_regs (
	input  logic           clk,
	input  logic           rst,
	input  logic           clk_en,
	input  fm_pkg::chan_t  slot,
	input  logic           upd_req,
	input  fm_pkg::chan_t  upd_ch,
	input  logic [1:0]     upd_kind,
	input  logic [7:0]     upd_data,
	output logic           upd_done,
	output fm_pkg::chan_t  out_slot,
	output fm_pkg::fnum_t  out_fnum,
	output fm_pkg::block_t out_block,
	output fm_pkg::fb_t    out_fb,
	output fm_pkg::alg_t   out_alg
);

	fm_pkg::fnum_t  fnum_mem  [fm_pkg::NUM_SLOTS];
	fm_pkg::block_t block_mem [fm_pkg::NUM_SLOTS];
	fm_pkg::fb_t    fb_mem    [fm_pkg::NUM_SLOTS];
	fm_pkg::alg_t   alg_mem   [fm_pkg::NUM_SLOTS];

	// block in 5:3, fnum top bits in 2:0
	logic [5:0]     hi_latch;
	logic           hit;
	fm_pkg::fnum_t  nxt_fnum;
	fm_pkg::block_t nxt_block;
	fm_pkg::fb_t    nxt_fb;
	fm_pkg::alg_t   nxt_alg;

	assign hit = clk_en & upd_req & (slot == upd_ch);

	// current slot entry with the pending update merged in
	always_comb begin
		nxt_fnum  = fnum_mem[slot];
		nxt_block = block_mem[slot];
		nxt_fb    = fb_mem[slot];
		nxt_alg   = alg_mem[slot];
		if (hit) begin
			case (upd_kind)
				fm_pkg::UPD_LO: begin
					nxt_fnum  = {hi_latch[2:0], upd_data};
					nxt_block = hi_latch[5:3];
				end
				fm_pkg::UPD_FBALG: begin
					nxt_fb  = upd_data[5:3];
					nxt_alg = upd_data[2:0];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
				fnum_mem[i]  <= '0;
				block_mem[i] <= '0;
				fb_mem[i]    <= '0;
				alg_mem[i]   <= '0;
			end
			hi_latch <= '0;
		end else if (hit) begin
			fnum_mem[slot]  <= nxt_fnum;
			block_mem[slot] <= nxt_block;
			fb_mem[slot]    <= nxt_fb;
			alg_mem[slot]   <= nxt_alg;
			// high byte only reaches the entry with the next low write
			if (upd_kind == fm_pkg::UPD_HI)
				hi_latch <= upd_data[5:0];
		end
	end

	// stream record and done pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			upd_done  <= 1'b0;
			out_slot  <= '0;
			out_fnum  <= '0;
			out_block <= '0;
			out_fb    <= '0;
			out_alg   <= '0;
		end else begin
			upd_done <= hit;
			if (clk_en) begin
				out_slot  <= slot;
				out_fnum  <= nxt_fnum;
				out_block <= nxt_block;
				out_fb    <= nxt_fb;
				out_alg   <= nxt_alg;
			end
		end
	end

endmodule

//--- source/fm_regs_top.sv
////////////////////////////////////////////////////////////////////////////
// FM register block top level
// timebase, host decoder, timers and channel store
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fm_regs_top #(
	parameter int TMR_B_PRE = 16
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           cen,
	input  logic [7:0]     din,
	input  logic [1:0]     addr,
	input  logic           write,
	output logic           busy,
	output logic           clk_en,
	output fm_pkg::chan_t  slot,
	output logic           flag_a,
	output logic           flag_b,
	output logic           irq,
	output fm_pkg::chan_t  out_slot,
	output fm_pkg::fnum_t  out_fnum,
	output fm_pkg::block_t out_block,
	output fm_pkg::fb_t    out_fb,
	output fm_pkg::alg_t   out_alg
);

	fm_pkg::div_t   div_lim;
	fm_pkg::tmr_a_t val_a;
	fm_pkg::tmr_b_t val_b;
	logic           load_a;
	logic           load_b;
	logic           irq_en_a;
	logic           irq_en_b;
	logic           clr_a;
	logic           clr_b;
	logic           upd_req;
	fm_pkg::chan_t  upd_ch;
	logic [1:0]     upd_kind;
	logic [7:0]     upd_data;
	logic           upd_done;

	fm_timebase u_timebase (
		.clk     (clk),
		.rst     (rst),
		.cen     (cen),
		.div_lim (div_lim),
		.clk_en  (clk_en),
		.slot    (slot)
	);

	fm_mmr u_mmr (
		.clk      (clk),
		.rst      (rst),
		.din      (din),
		.addr     (addr),
		.write    (write),
		.clk_en   (clk_en),
		.busy     (busy),
		.div_lim  (div_lim),
		.val_a    (val_a),
		.val_b    (val_b),
		.load_a   (load_a),
		.load_b   (load_b),
		.irq_en_a (irq_en_a),
		.irq_en_b (irq_en_b),
		.clr_a    (clr_a),
		.clr_b    (clr_b),
		.upd_req  (upd_req),
		.upd_ch   (upd_ch),
		.upd_kind (upd_kind),
		.upd_data (upd_data),
		.upd_done (upd_done)
	);

	fm_timers #(
		.TMR_B_PRE (TMR_B_PRE)
	) u_timers (
		.clk      (clk),
		.rst      (rst),
		.clk_en   (clk_en),
		.val_a    (val_a),
		.val_b    (val_b),
		.load_a   (load_a),
		.load_b   (load_b),
		.irq_en_a (irq_en_a),
		.irq_en_b (irq_en_b),
		.clr_a    (clr_a),
		.clr_b    (clr_b),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.irq      (irq)
	);

	fm_chan_regs u_chan_regs (
		.clk       (clk),
		.rst       (rst),
		.clk_en    (clk_en),
		.slot      (slot),
		.upd_req   (upd_req),
		.upd_ch    (upd_ch),
		.upd_kind  (upd_kind),
		.upd_data  (upd_data),
		.upd_done  (upd_done),
		.out_slot  (out_slot),
		.out_fnum  (out_fnum),
		.out_block (out_block),
		.out_fb    (out_fb),
		.out_alg   (out_alg)
	);

endmodule

//--- test/fm_regs_chk.sv
////////////////////////////////////////////////////////////////////////////
// FM register block assertions
// reset, slot stepping, clk_en spacing and interrupt timing checks,
// bound onto the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fm_regs_chk (
	input logic          clk,
	input logic          rst,
	input logic          busy,
	input logic          clk_en,
	input fm_pkg::chan_t slot,
	input logic          flag_a,
	input logic          flag_b,
	input logic          irq
);

	logic [2:0] slot_next;

	// slot that should follow a clk_en
	assign slot_next = (slot == 3'd5) ? 3'd0 : slot + 3'd1;

	busy_after_rst: assert property (@(posedge clk) $fell(rst) |-> !busy)
		else $error("busy high on the first clk after reset");

	slot_on_en: assert property (@(posedge clk) disable iff (rst)
		clk_en |=> (slot == $past(slot_next)))
		else $error("slot did not advance on clk_en");

	slot_hold: assert property (@(posedge clk) disable iff (rst)
		!clk_en |=> (slot == $past(slot)))
		else $error("slot changed without clk_en");

	en_single: assert property (@(posedge clk) disable iff (rst) clk_en |=> !clk_en)
		else $error("clk_en high on two consecutive clks");

	irq_follow: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> (irq == $past(flag_a | flag_b)))
		else $error("irq does not follow the timer flags");

endmodule

bind fm_regs_top fm_regs_chk chk0 (
	.clk    (clk),
	.rst    (rst),
	.busy   (busy),
	.clk_en (clk_en),
	.slot   (slot),
	.flag_a (flag_a),
	.flag_b (flag_b),
	.irq    (irq)
);

//--- test/fm_regs_tb.sv
////////////////////////////////////////////////////////////////////////////
// FM register block testbench
// directed tests of divider, channel store, busy and both timers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fm_regs_tb;

	// longest test path is a few thousand clks
	localparam int CYCLE_LIMIT = 20000;
	localparam int KIND_LO     = 0;
	localparam int KIND_HI     = 1;
	localparam int KIND_FBALG  = 2;

	logic        clk;
	logic        rst;
	logic        cen;
	logic [7:0]  din;
	logic [1:0]  addr;
	logic        write;
	logic        busy;
	logic        clk_en;
	logic [2:0]  slot;
	logic        flag_a;
	logic        flag_b;
	logic        irq;
	logic [2:0]  out_slot;
	logic [10:0] out_fnum;
	logic [2:0]  out_block;
	logic [2:0]  out_fb;
	logic [2:0]  out_alg;
	int          cycles = 0;
	int          en_cnt = 0;
	int          mark;

	// expected channel store and high-byte latch
	logic [10:0] exp_fnum  [6];
	logic [2:0]  exp_block [6];
	logic [2:0]  exp_fb    [6];
	logic [2:0]  exp_alg   [6];
	logic [5:0]  exp_latch;

	fm_regs_top #(.TMR_B_PRE(4)) dut0 (
		.clk       (clk),
		.rst       (rst),
		.cen       (cen),
		.din       (din),
		.addr      (addr),
		.write     (write),
		.busy      (busy),
		.clk_en    (clk_en),
		.slot      (slot),
		.flag_a    (flag_a),
		.flag_b    (flag_b),
		.irq       (irq),
		.out_slot  (out_slot),
		.out_fnum  (out_fnum),
		.out_block (out_block),
		.out_fb    (out_fb),
		.out_alg   (out_alg)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// clk counter for the timeout, clk_en counter for timer ticks
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (clk_en)
			en_cnt <= en_cnt + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: no verdict after %0d clock cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// address write, data write, then wait for busy to drop
	task automatic bus_write(input logic hi, input logic [7:0] num,
		input logic [7:0] val, input int max_en);
		int seen;
		@(posedge clk);
		addr  <= {hi, 1'b0};
		din   <= num;
		write <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
		@(posedge clk);
		addr  <= {hi, 1'b1};
		din   <= val;
		write <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
		@(negedge clk);
		mark = en_cnt;
		check_value("busy after data write", busy, 1);
		seen = 0;
		while (busy) begin
			if (clk_en)
				seen++;
			@(negedge clk);
		end
		check_value("busy released within clk_en limit", seen <= max_en, 1);
	endtask

	task automatic global_write(input logic [7:0] num, input logic [7:0] val);
		bus_write(1'b0, num, val, 1);
	endtask

	task automatic chan_write(input int ch, input int kind, input logic [7:0] d);
		logic [7:0] base;
		base = (kind == KIND_LO) ? 8'hA0 : (kind == KIND_HI) ? 8'hA4 : 8'hB0;
		bus_write(ch >= 3, base + 8'(ch % 3), d, 7);
		case (kind)
			KIND_LO: begin
				exp_fnum[ch]  = {exp_latch[2:0], d};
				exp_block[ch] = exp_latch[5:3];
			end
			KIND_HI: exp_latch = d[5:0];
			default: begin
				exp_fb[ch]  = d[5:3];
				exp_alg[ch] = d[2:0];
			end
		endcase
	endtask

	// next stream record of a channel against the expected store
	task automatic check_record(input int ch);
		@(negedge clk);
		while (!(clk_en && slot == ch))
			@(negedge clk);
		@(negedge clk);
		check_value("out_slot", out_slot, ch);
		check_value("out_fnum", out_fnum, exp_fnum[ch]);
		check_value("out_block", out_block, exp_block[ch]);
		check_value("out_fb", out_fb, exp_fb[ch]);
		check_value("out_alg", out_alg, exp_alg[ch]);
	endtask

	task automatic clk_en_gap(output int gap);
		@(negedge clk);
		while (!clk_en)
			@(negedge clk);
		gap = 0;
		do begin
			@(negedge clk);
			gap++;
		end while (!clk_en);
	endtask

	task automatic ticks_to_flag(input logic use_b, output int ticks);
		while (!(use_b ? flag_b : flag_a))
			@(negedge clk);
		ticks = en_cnt - mark;
	endtask

	task automatic divider_ratios;
		int gap;
		clk_en_gap(gap);
		check_value("clk_en gap after reset", gap, 6);
		global_write(fm_pkg::REG_DIV3, 8'h00);
		clk_en_gap(gap);
		clk_en_gap(gap);
		check_value("clk_en gap at ratio 3", gap, 3);
		global_write(fm_pkg::REG_DIV2, 8'h00);
		clk_en_gap(gap);
		clk_en_gap(gap);
		check_value("clk_en gap at ratio 2", gap, 2);
		global_write(fm_pkg::REG_DIV6, 8'h00);
		clk_en_gap(gap);
		clk_en_gap(gap);
		check_value("clk_en gap at ratio 6", gap, 6);
	endtask

	task automatic channel_params;
		logic [31:0] r;
		for (int ch = 0; ch < 6; ch++) begin
			r = $urandom;
			// bits 7:6 of the high byte are don't care
			chan_write(ch, KIND_HI, {r[21:20], r[2:0], r[13:11]});
			chan_write(ch, KIND_LO, r[10:3]);
			chan_write(ch, KIND_FBALG, {r[23:22], r[16:14], r[19:17]});
			check_record(ch);
		end
	endtask

	task automatic latch_order;
		chan_write(1, KIND_HI, {2'b00, ~exp_block[1], ~exp_fnum[1][10:8]});
		check_record(1);
		chan_write(1, KIND_LO, ~exp_fnum[1][7:0]);
		check_record(1);
	endtask

	// numbers ending in 3 decode to nothing
	task automatic ignored_regs;
		bus_write(1'b0, 8'hA3, 8'hFF, 1);
		bus_write(1'b1, 8'hA7, 8'hFF, 1);
		bus_write(1'b0, 8'hB3, 8'hFF, 1);
		for (int ch = 0; ch < 6; ch++)
			check_record(ch);
	endtask

	task automatic timer_a_overflow;
		int ticks;
		int start;
		// 1020 gives 4 ticks to overflow
		global_write(fm_pkg::REG_CLKA1, 8'hFF);
		global_write(fm_pkg::REG_CLKA2, 8'h00);
		global_write(fm_pkg::REG_TIMER, 8'h05);
		ticks_to_flag(1'b0, ticks);
		check_value("timer A ticks to flag", ticks, 4);
		start = en_cnt;
		@(negedge clk);
		check_value("irq after flag_a", irq, 1);
		// clear with load and enable kept so the counter reloads by itself
		global_write(fm_pkg::REG_TIMER, 8'h15);
		@(negedge clk);
		check_value("flag_a after clear", flag_a, 0);
		check_value("irq after clear", irq, 0);
		while (!flag_a)
			@(negedge clk);
		check_value("timer A reload period", en_cnt - start, 4);
		global_write(fm_pkg::REG_TIMER, 8'h10);
	endtask

	task automatic timer_b_overflow;
		int ticks;
		global_write(fm_pkg::REG_CLKB, 8'hFE);
		global_write(fm_pkg::REG_TIMER, 8'h0A);
		ticks_to_flag(1'b1, ticks);
		check_value("timer B ticks to flag", ticks, 8);
		@(negedge clk);
		check_value("irq after flag_b", irq, 1);
		global_write(fm_pkg::REG_TIMER, 8'h20);
		@(negedge clk);
		check_value("flag_b after clear", flag_b, 0);
		// three overflow periods with the enable clear
		global_write(fm_pkg::REG_TIMER, 8'h02);
		while (en_cnt - mark < 24) begin
			check_value("flag_b with enable clear", flag_b, 0);
			@(negedge clk);
		end
	endtask

	initial begin
		rst   = 1'b1;
		cen   = 1'b1;
		write = 1'b0;
		din   = 8'h00;
		addr  = 2'b00;
		void'($urandom(32'hfc61_2bd8));
		exp_latch = '0;
		for (int i = 0; i < 6; i++) begin
			exp_fnum[i]  = '0;
			exp_block[i] = '0;
			exp_fb[i]    = '0;
			exp_alg[i]   = '0;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		divider_ratios();
		channel_params();
		latch_order();
		ignored_regs();
		timer_a_overflow();
		timer_b_overflow();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- fm_regs_top.f
source/fm_pkg.sv
source/fm_timebase.sv
source/fm_mmr.sv
source/fm_timers.sv
source/fm_chan_regs.sv
source/fm_regs_top.sv
test/fm_regs_chk.sv
test/fm_regs_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the FM register block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f fm_regs_top.f --top-module fm_regs_tb

# the simulator exits non-zero on a fatal check, the grep decides the verdict
out=$(./obj_dir/Vfm_regs_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1
